// File: Makefile
# Verilator build for the AXI4 SRAM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_sram
SEED      ?= 0
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: compile
	@out="$$($(SIM_BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
rtl/axi_sram_pkg.sv
rtl/sram_cmd_if.sv
rtl/sram_rd_resp_if.sv
rtl/axi_sram_wr.sv
rtl/axi_sram_rd.sv
rtl/axi_sram_arbiter.sv
rtl/sram_mem.sv
rtl/axi_sram_top.sv
tb/tb_axi_sram.sv

// File: rtl/axi_sram_arbiter.sv
`timescale 1ns/100ps

module axi_sram_arbiter (
  input  logic         clk,
  input  logic         rst_n,

  sram_cmd_if.executor wr,
  sram_cmd_if.executor rd,
  sram_cmd_if.issuer   mem
);

  logic read_first;
  logic grant_rd;
  logic grant_wr;

  // Reads win when favoured or when no write is pending
  assign grant_rd = rd.valid && (read_first || !wr.valid);
  assign grant_wr = wr.valid && !grant_rd;

  assign mem.valid   = grant_rd || grant_wr;
  assign mem.wr_en   = grant_rd ? rd.wr_en   : wr.wr_en;
  assign mem.addr    = grant_rd ? rd.addr    : wr.addr;
  assign mem.meta    = grant_rd ? rd.meta    : wr.meta;
  assign mem.wr_data = grant_rd ? rd.wr_data : wr.wr_data;
  assign mem.wr_strb = grant_rd ? rd.wr_strb : wr.wr_strb;

  // Only the winner sees the memory ready
  assign rd.ready = grant_rd && mem.ready;
  assign wr.ready = grant_wr && mem.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_first <= 1'b0;
    end else if (wr.valid && wr.ready) begin
      read_first <= 1'b1;
    end else if (rd.valid && rd.ready) begin
      read_first <= 1'b0;
    end
  end

endmodule

// File: rtl/axi_sram_pkg.sv
package axi_sram_pkg;

  // AXI burst encodings; only INCR is honoured by the bridge
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

  localparam int DEF_ADDR_WIDTH = 16;
  localparam int DEF_DATA_WIDTH = 16;
  localparam int DEF_ID_WIDTH   = 4;

endpackage

// File: rtl/axi_sram_rd.sv
`timescale 1ns/100ps

module axi_sram_rd #(
  parameter int ADDR_WIDTH      = axi_sram_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH      = axi_sram_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH        = axi_sram_pkg::DEF_ID_WIDTH,
  parameter int STRB_WIDTH      = DATA_WIDTH / 8,
  parameter int LSB             = $clog2(DATA_WIDTH) - 3,
  parameter int SRAM_ADDR_WIDTH = ADDR_WIDTH - LSB,
  parameter int META_WIDTH      = ID_WIDTH + 1
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        arvalid,
  output logic                        arready,
  input  logic [ID_WIDTH-1:0]         arid,
  input  logic [ADDR_WIDTH-1:0]       araddr,
  input  logic [7:0]                  arlen,
  input  axi_sram_pkg::axi_burst_t    arburst,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [ID_WIDTH-1:0]         rid,
  output logic [DATA_WIDTH-1:0]       rdata,
  output axi_sram_pkg::axi_resp_t     rresp,
  output logic                        rlast,

  sram_cmd_if.issuer                  cmd,
  sram_rd_resp_if.sink                resp
);
  import axi_sram_pkg::*;

  logic                       busy;
  logic                       issuing;
  logic [ID_WIDTH-1:0]        id;
  logic [SRAM_ADDR_WIDTH-1:0] addr;
  logic [7:0]                 beats_left;
  logic                       issue_last;
  logic                       cmd_done;
  logic                       resp_done;

  // Burst type is accepted but every burst advances as INCR
  assign arready = !busy;

  assign issue_last = (beats_left == 8'd0);
  assign cmd_done   = cmd.valid && cmd.ready;

  assign cmd.valid   = issuing;
  assign cmd.wr_en   = 1'b0;
  assign cmd.addr    = addr;
  assign cmd.meta    = {id, issue_last};
  assign cmd.wr_data = '0;
  assign cmd.wr_strb = '0;

  // R follows the memory response directly
  assign rvalid     = resp.valid;
  assign resp.ready = rready;
  assign rdata      = resp.data;
  assign rid        = resp.meta[META_WIDTH-1:1];
  assign rlast      = resp.meta[0];
  assign rresp      = RESP_OKAY;

  assign resp_done = resp.valid && rready && resp.meta[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      issuing <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        busy    <= 1'b1;
        issuing <= 1'b1;
      end else begin
        if (cmd_done && issue_last) begin
          issuing <= 1'b0;
        end
        // Burst ends when the last beat has left on R
        if (resp_done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      id         <= arid;
      addr       <= araddr[ADDR_WIDTH-1:LSB];
      beats_left <= arlen;
    end else if (cmd_done) begin
      addr       <= addr + 1'b1;
      beats_left <= beats_left - 8'd1;
    end
  end

endmodule

// File: rtl/axi_sram_top.sv
`timescale 1ns/100ps

module axi_sram_top #(
  parameter int ADDR_WIDTH      = axi_sram_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH      = axi_sram_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH        = axi_sram_pkg::DEF_ID_WIDTH,
  parameter int STRB_WIDTH      = DATA_WIDTH / 8,
  parameter int LSB             = $clog2(DATA_WIDTH) - 3,
  parameter int SRAM_ADDR_WIDTH = ADDR_WIDTH - LSB,
  parameter int META_WIDTH      = ID_WIDTH + 1,
  parameter int DEPTH           = 2 ** SRAM_ADDR_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  logic [ID_WIDTH-1:0]      s_axi_awid,
  input  logic [ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  logic [7:0]               s_axi_awlen,
  input  axi_sram_pkg::axi_burst_t s_axi_awburst,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  input  logic [DATA_WIDTH-1:0]    s_axi_wdata,
  input  logic [STRB_WIDTH-1:0]    s_axi_wstrb,
  input  logic                     s_axi_wlast,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  output logic [ID_WIDTH-1:0]      s_axi_bid,
  output axi_sram_pkg::axi_resp_t  s_axi_bresp,

  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  input  logic [ID_WIDTH-1:0]      s_axi_arid,
  input  logic [ADDR_WIDTH-1:0]    s_axi_araddr,
  input  logic [7:0]               s_axi_arlen,
  input  axi_sram_pkg::axi_burst_t s_axi_arburst,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  output logic [ID_WIDTH-1:0]      s_axi_rid,
  output logic [DATA_WIDTH-1:0]    s_axi_rdata,
  output axi_sram_pkg::axi_resp_t  s_axi_rresp,
  output logic                     s_axi_rlast
);

  sram_cmd_if #(
    .ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .STRB_WIDTH(STRB_WIDTH),
    .META_WIDTH(META_WIDTH)
  ) wr_cmd ();

  sram_cmd_if #(
    .ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .STRB_WIDTH(STRB_WIDTH),
    .META_WIDTH(META_WIDTH)
  ) rd_cmd ();

  sram_cmd_if #(
    .ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .STRB_WIDTH(STRB_WIDTH),
    .META_WIDTH(META_WIDTH)
  ) mem_cmd ();

  sram_rd_resp_if #(
    .DATA_WIDTH(DATA_WIDTH),
    .META_WIDTH(META_WIDTH)
  ) rd_resp ();

  axi_sram_wr #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .ID_WIDTH       (ID_WIDTH),
    .STRB_WIDTH     (STRB_WIDTH),
    .LSB            (LSB),
    .SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH)
  ) u_wr (
    .clk    (clk),
    .rst_n  (rst_n),
    .awvalid(s_axi_awvalid),
    .awready(s_axi_awready),
    .awid   (s_axi_awid),
    .awaddr (s_axi_awaddr),
    .awlen  (s_axi_awlen),
    .awburst(s_axi_awburst),
    .wvalid (s_axi_wvalid),
    .wready (s_axi_wready),
    .wdata  (s_axi_wdata),
    .wstrb  (s_axi_wstrb),
    .wlast  (s_axi_wlast),
    .bvalid (s_axi_bvalid),
    .bready (s_axi_bready),
    .bid    (s_axi_bid),
    .bresp  (s_axi_bresp),
    .cmd    (wr_cmd.issuer)
  );

  axi_sram_rd #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .ID_WIDTH       (ID_WIDTH),
    .STRB_WIDTH     (STRB_WIDTH),
    .LSB            (LSB),
    .SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .META_WIDTH     (META_WIDTH)
  ) u_rd (
    .clk    (clk),
    .rst_n  (rst_n),
    .arvalid(s_axi_arvalid),
    .arready(s_axi_arready),
    .arid   (s_axi_arid),
    .araddr (s_axi_araddr),
    .arlen  (s_axi_arlen),
    .arburst(s_axi_arburst),
    .rvalid (s_axi_rvalid),
    .rready (s_axi_rready),
    .rid    (s_axi_rid),
    .rdata  (s_axi_rdata),
    .rresp  (s_axi_rresp),
    .rlast  (s_axi_rlast),
    .cmd    (rd_cmd.issuer),
    .resp   (rd_resp.sink)
  );

  axi_sram_arbiter u_arbiter (
    .clk  (clk),
    .rst_n(rst_n),
    .wr   (wr_cmd.executor),
    .rd   (rd_cmd.executor),
    .mem  (mem_cmd.issuer)
  );

  sram_mem #(
    .DATA_WIDTH     (DATA_WIDTH),
    .STRB_WIDTH     (STRB_WIDTH),
    .SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .META_WIDTH     (META_WIDTH),
    .DEPTH          (DEPTH)
  ) u_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .cmd  (mem_cmd.executor),
    .resp (rd_resp.source)
  );

endmodule

// File: rtl/axi_sram_wr.sv
`timescale 1ns/100ps

module axi_sram_wr #(
  parameter int ADDR_WIDTH      = axi_sram_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH      = axi_sram_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH        = axi_sram_pkg::DEF_ID_WIDTH,
  parameter int STRB_WIDTH      = DATA_WIDTH / 8,
  parameter int LSB             = $clog2(DATA_WIDTH) - 3,
  parameter int SRAM_ADDR_WIDTH = ADDR_WIDTH - LSB
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        awvalid,
  output logic                        awready,
  input  logic [ID_WIDTH-1:0]         awid,
  input  logic [ADDR_WIDTH-1:0]       awaddr,
  input  logic [7:0]                  awlen,
  input  axi_sram_pkg::axi_burst_t    awburst,
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [DATA_WIDTH-1:0]       wdata,
  input  logic [STRB_WIDTH-1:0]       wstrb,
  input  logic                        wlast,
  output logic                        bvalid,
  input  logic                        bready,
  output logic [ID_WIDTH-1:0]         bid,
  output axi_sram_pkg::axi_resp_t     bresp,

  sram_cmd_if.issuer                  cmd
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t                     state;
  logic [ID_WIDTH-1:0]        id;
  logic [SRAM_ADDR_WIDTH-1:0] addr;
  logic                       beat_done;

  // Burst type is accepted but every burst advances as INCR
  assign awready = (state == ST_IDLE);

  assign cmd.valid   = (state == ST_DATA) && wvalid;
  assign cmd.wr_en   = 1'b1;
  assign cmd.addr    = addr;
  assign cmd.meta    = '0;
  assign cmd.wr_data = wdata;
  assign cmd.wr_strb = wstrb;

  assign wready    = (state == ST_DATA) && cmd.ready;
  assign beat_done = cmd.valid && cmd.ready;

  assign bvalid = (state == ST_RESP);
  assign bid    = id;
  assign bresp  = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (awvalid) state <= ST_DATA;
        ST_DATA: if (beat_done && wlast) state <= ST_RESP;
        ST_RESP: if (bready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      id   <= awid;
      addr <= awaddr[ADDR_WIDTH-1:LSB];
    end else if (beat_done) begin
      addr <= addr + 1'b1;
    end
  end

endmodule

// File: rtl/sram_cmd_if.sv
`timescale 1ns/100ps

interface sram_cmd_if #(
  parameter int ADDR_WIDTH = 15,
  parameter int DATA_WIDTH = 16,
  parameter int STRB_WIDTH = DATA_WIDTH / 8,
  parameter int META_WIDTH = 5
);

  logic                  valid;
  logic                  ready;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] addr;
  logic [META_WIDTH-1:0] meta;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  modport issuer (output valid, wr_en, addr, meta, wr_data, wr_strb, input ready);

  modport executor (input valid, wr_en, addr, meta, wr_data, wr_strb, output ready);

endinterface

// File: rtl/sram_mem.sv
`timescale 1ns/100ps

module sram_mem #(
  parameter int DATA_WIDTH      = 16,
  parameter int STRB_WIDTH      = DATA_WIDTH / 8,
  parameter int SRAM_ADDR_WIDTH = 15,
  parameter int META_WIDTH      = 5,
  parameter int DEPTH           = 2 ** SRAM_ADDR_WIDTH
) (
  input  logic           clk,
  input  logic           rst_n,

  sram_cmd_if.executor   cmd,
  sram_rd_resp_if.source resp
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  logic                  resp_valid;
  logic [DATA_WIDTH-1:0] resp_data;
  logic [META_WIDTH-1:0] resp_meta;
  logic                  accept;
  logic                  rd_accept;

  // A held response that is not taken stalls the port
  assign cmd.ready = !resp_valid || resp.ready;
  assign accept    = cmd.valid && cmd.ready;
  assign rd_accept = accept && !cmd.wr_en;

  assign resp.valid = resp_valid;
  assign resp.data  = resp_data;
  assign resp.meta  = resp_meta;

  always_ff @(posedge clk) begin
    if (accept && cmd.wr_en) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (cmd.wr_strb[i]) begin
          mem[cmd.addr][8*i +: 8] <= cmd.wr_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      resp_data <= mem[cmd.addr];
      resp_meta <= cmd.meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_accept) begin
      resp_valid <= 1'b1;
    end else if (resp.ready) begin
      resp_valid <= 1'b0;
    end
  end

endmodule

// File: rtl/sram_rd_resp_if.sv
`timescale 1ns/100ps

interface sram_rd_resp_if #(
  parameter int DATA_WIDTH = 16,
  parameter int META_WIDTH = 5
);

  logic                  valid;
  logic                  ready;
  logic [DATA_WIDTH-1:0] data;
  logic [META_WIDTH-1:0] meta;

  modport source (output valid, data, meta, input ready);

  modport sink (input valid, data, meta, output ready);

endinterface

// File: tb/tb_axi_sram.sv
`timescale 1ns/100ps

module tb_axi_sram;
  import axi_sram_pkg::*;

  localparam int ADDR_W  = DEF_ADDR_WIDTH;
  localparam int DATA_W  = DEF_DATA_WIDTH;
  localparam int ID_W    = DEF_ID_WIDTH;
  localparam int STRB_W  = DATA_W / 8;
  localparam int TIMEOUT = 1000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              s_axi_awvalid;
  logic              s_axi_awready;
  logic [ID_W-1:0]   s_axi_awid;
  logic [ADDR_W-1:0] s_axi_awaddr;
  logic [7:0]        s_axi_awlen;
  axi_burst_t        s_axi_awburst;
  logic              s_axi_wvalid;
  logic              s_axi_wready;
  logic [DATA_W-1:0] s_axi_wdata;
  logic [STRB_W-1:0] s_axi_wstrb;
  logic              s_axi_wlast;
  logic              s_axi_bvalid;
  logic              s_axi_bready;
  logic [ID_W-1:0]   s_axi_bid;
  axi_resp_t         s_axi_bresp;
  logic              s_axi_arvalid;
  logic              s_axi_arready;
  logic [ID_W-1:0]   s_axi_arid;
  logic [ADDR_W-1:0] s_axi_araddr;
  logic [7:0]        s_axi_arlen;
  axi_burst_t        s_axi_arburst;
  logic              s_axi_rvalid;
  logic              s_axi_rready;
  logic [ID_W-1:0]   s_axi_rid;
  logic [DATA_W-1:0] s_axi_rdata;
  axi_resp_t         s_axi_rresp;
  logic              s_axi_rlast;

  integer            seed = 9637;

  // Byte-wide model of the SRAM contents
  logic [7:0]        model_mem [2**ADDR_W];

  axi_sram_top uut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = next_random();
    return r[0];
  endfunction

  function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] ba);
    logic [DATA_W-1:0] w;
    for (int b = 0; b < STRB_W; b++) begin
      w[8*b +: 8] = model_mem[ba + ADDR_W'(b)];
    end
    return w;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] ba, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        model_mem[ba + ADDR_W'(b)] = data[8*b +: 8];
      end
    end
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else
      fail_now($sformatf("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  // AW and the first W beat go out together, then B is collected
  task automatic write_burst(input int addr, input int len, input logic [ID_W-1:0] id,
                             input logic [STRB_W-1:0] strb, input bit stall);
    logic [DATA_W-1:0] data [$];
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] ba;
    bit                hs;
    int                beat;
    int                cycles;

    for (int i = 0; i <= len; i++) begin
      rnd = next_random();
      data.push_back(rnd[DATA_W-1:0]);
    end
    @(posedge clk);
    s_axi_awvalid <= 1'b1;
    s_axi_awid    <= id;
    s_axi_awaddr  <= addr[ADDR_W-1:0];
    s_axi_awlen   <= len[7:0];
    s_axi_awburst <= BURST_INCR;
    s_axi_wvalid  <= 1'b1;
    s_axi_wdata   <= data[0];
    s_axi_wstrb   <= strb;
    s_axi_wlast   <= (len == 0);
    cycles = 0;
    do begin
      @(negedge clk);
      hs = s_axi_awready;
      @(posedge clk);
      cycles++;
      if (!hs && cycles > TIMEOUT) fail_now("Timeout: awready never came high");
    end while (!hs);
    s_axi_awvalid <= 1'b0;

    beat = 0;
    cycles = 0;
    while (beat <= len) begin
      @(negedge clk);
      hs = s_axi_wready;
      @(posedge clk);
      cycles++;
      if (hs) begin
        beat++;
        cycles = 0;
        if (beat <= len) begin
          s_axi_wdata <= data[beat];
          s_axi_wlast <= (beat == len);
        end else begin
          s_axi_wvalid <= 1'b0;
          s_axi_wlast  <= 1'b0;
        end
      end else if (cycles > TIMEOUT) begin
        fail_now("Timeout: write data beat was never accepted");
      end
    end

    s_axi_bready <= stall ? random_bit() : 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      hs = s_axi_bvalid && s_axi_bready;
      if (hs) begin
        check_eq(32'(s_axi_bid), 32'(id), "bid");
        check_eq(32'(s_axi_bresp), 32'(RESP_OKAY), "bresp");
      end
      @(posedge clk);
      cycles++;
      if (!hs) begin
        if (cycles > TIMEOUT) fail_now("Timeout: write response never arrived");
        s_axi_bready <= stall ? random_bit() : 1'b1;
      end
    end while (!hs);
    s_axi_bready <= 1'b0;

    for (int i = 0; i <= len; i++) begin
      ba = addr[ADDR_W-1:0] + ADDR_W'(STRB_W * i);
      model_write(ba, data[i], strb);
    end
  endtask

  task automatic read_burst(input int addr, input int len, input logic [ID_W-1:0] id,
                            input bit stall);
    logic [ADDR_W-1:0] ba;
    bit                hs;
    int                beat;
    int                cycles;

    @(posedge clk);
    s_axi_arvalid <= 1'b1;
    s_axi_arid    <= id;
    s_axi_araddr  <= addr[ADDR_W-1:0];
    s_axi_arlen   <= len[7:0];
    s_axi_arburst <= BURST_INCR;
    s_axi_rready  <= stall ? random_bit() : 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      hs = s_axi_arready;
      @(posedge clk);
      cycles++;
      if (!hs && cycles > TIMEOUT) fail_now("Timeout: arready never came high");
    end while (!hs);
    s_axi_arvalid <= 1'b0;

    beat = 0;
    cycles = 0;
    while (beat <= len) begin
      @(negedge clk);
      hs = s_axi_rvalid && s_axi_rready;
      if (hs) begin
        ba = addr[ADDR_W-1:0] + ADDR_W'(STRB_W * beat);
        check_eq(32'(s_axi_rdata), 32'(model_word(ba)), "rdata");
        check_eq(32'(s_axi_rid), 32'(id), "rid");
        check_eq(32'(s_axi_rresp), 32'(RESP_OKAY), "rresp");
        check_eq(32'(s_axi_rlast), 32'(beat == len), "rlast");
      end
      @(posedge clk);
      cycles++;
      if (hs) begin
        beat++;
        cycles = 0;
      end else if (cycles > TIMEOUT) begin
        fail_now("Timeout: read data beat never arrived");
      end
      s_axi_rready <= stall ? random_bit() : 1'b1;
    end
    s_axi_rready <= 1'b0;
    // Nothing may follow the beat flagged last
    @(negedge clk);
    check_eq(32'(s_axi_rvalid), 32'd0, "rvalid after last beat");
  endtask

  initial begin
    logic [31:0] rnd;
    int          len;
    int          addr;

    rst_n         <= 1'b0;
    s_axi_awvalid <= 1'b0;
    s_axi_awid    <= '0;
    s_axi_awaddr  <= '0;
    s_axi_awlen   <= '0;
    s_axi_awburst <= BURST_INCR;
    s_axi_wvalid  <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wlast   <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_arvalid <= 1'b0;
    s_axi_arid    <= '0;
    s_axi_araddr  <= '0;
    s_axi_arlen   <= '0;
    s_axi_arburst <= BURST_INCR;
    s_axi_rready  <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_eq(32'(s_axi_awready), 32'd1, "awready after reset");
    check_eq(32'(s_axi_arready), 32'd1, "arready after reset");
    check_eq(32'(s_axi_bvalid), 32'd0, "bvalid after reset");
    check_eq(32'(s_axi_rvalid), 32'd0, "rvalid after reset");

    write_burst('h0100, 0, 4'h3, '1, 1'b0);
    read_burst('h0100, 0, 4'h5, 1'b0);

    // Partial strobes over a fully written region
    write_burst('h0200, 3, 4'h1, '1, 1'b0);
    write_burst('h0200, 3, 4'h2, 2'b01, 1'b0);
    write_burst('h0204, 0, 4'hc, 2'b10, 1'b0);
    read_burst('h0200, 3, 4'h4, 1'b0);

    for (int i = 0; i < 20; i++) begin
      rnd  = next_random();
      len  = int'(rnd[3:0]);
      addr = 'h4000 + int'(rnd[16:4]) * STRB_W;
      write_burst(addr, len, rnd[23:20], '1, 1'b0);
      read_burst(addr, len, rnd[27:24], 1'b0);
    end

    write_burst('h1000, 7, 4'h6, '1, 1'b0);
    fork
      write_burst('h2000, 7, 4'h7, '1, 1'b0);
      read_burst('h1000, 7, 4'h8, 1'b0);
    join
    read_burst('h2000, 7, 4'h9, 1'b0);

    // Random rready and bready stalls
    for (int i = 0; i < 8; i++) begin
      rnd  = next_random();
      len  = int'(rnd[3:0]);
      addr = 'h8000 + int'(rnd[16:4]) * STRB_W;
      write_burst(addr, len, rnd[23:20], '1, 1'b1);
      read_burst(addr, len, rnd[27:24], 1'b1);
    end
    fork
      write_burst('h3000, 15, 4'ha, '1, 1'b1);
      read_burst('h1000, 7, 4'hb, 1'b1);
    join
    read_burst('h3000, 15, 4'hd, 1'b1);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
